//--- all.f
rtl/dbg_pkg.sv
rtl/dbg_retire_decoder.sv
rtl/dbg_fifo.sv
rtl/dbg_cause_tracker.sv
rtl/dbg_entry_predictor.sv
testbench/dbg_entry_predictor_chk.sv
testbench/tb_dbg_entry_predictor.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the debug entry predictor testbench with Verilator, runs it
# and decides pass or fail from the simulation log

TOP=tb_dbg_entry_predictor
OBJ_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module "${TOP}" -Mdir "${OBJ_DIR}" -f all.f
status=$?
if [ "${status}" -ne 0 ]; then
  echo "Verilator build failed with status ${status}"
  exit 1
fi

"./${OBJ_DIR}/V${TOP}" 2>&1 | tee "${LOG}"
status=${PIPESTATUS[0]}
if [ "${status}" -ne 0 ]; then
  echo "Simulation exited with status ${status}"
  exit 1
fi

if grep -q "RESULT: FAIL" "${LOG}"; then
  echo "Simulation reported a failure, see ${LOG}"
  exit 1
fi

if ! grep -q "RESULT: PASS" "${LOG}"; then
  echo "Simulation ended without a pass line, see ${LOG}"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- testbench/tb_dbg_entry_predictor.sv
// ----------------------------------------
// Debug entry predictor testbench
// Directed and LFSR driven retire beats,
// checked against a reference model
// ----------------------------------------

`timescale 1ns/1ps

module tb_dbg_entry_predictor;

  localparam int N_DIRECTED     = 23;
  localparam int N_RANDOM       = 300;
  localparam int TIMEOUT_CYCLES = 8 * (N_DIRECTED + N_RANDOM) + 2000;
  localparam int DRAIN_LIMIT    = 64;
  // Record free cycles that mark an empty pipeline
  localparam int QUIET_CYCLES   = 12;

  logic                      cov_assert_if = 1'b0;
  logic                      rst_n_i;
  logic                      ret_valid_i;
  logic                      ret_ready_o;
  logic [dbg_pkg::XLEN-1:0]  ret_instr_i;
  logic [dbg_pkg::XLEN-1:0]  ret_pc_i;
  logic [dbg_pkg::XLEN-1:0]  ret_npc_i;
  logic                      ret_err_i;
  logic                      debug_req_i;
  logic                      dcsr_ebreakm_i;
  logic                      dcsr_step_i;
  logic                      trig_en_i;
  logic [dbg_pkg::XLEN-1:0]  tdata2_i;
  logic                      rec_valid_o;
  logic                      rec_ready_i;
  dbg_pkg::dbg_cause_e       rec_cause_o;
  logic [dbg_pkg::XLEN-1:0]  rec_dpc_o;
  logic                      debug_mode_o;

  // Reference model state and expected records
  logic                      model_debug = 1'b0;
  logic [dbg_pkg::XLEN-1:0]  model_dpc = '0;
  dbg_pkg::dbg_cause_e       exp_cause_q[$];
  logic [dbg_pkg::XLEN-1:0]  exp_dpc_q[$];

  string                     test_name = "reset";
  int                        value_errors = 0;
  int                        other_errors = 0;
  int                        records_checked = 0;
  int                        cycle_count = 0;
  logic [15:0]               lfsr = 16'd63;
  logic                      bp_en = 1'b0;

  dbg_entry_predictor u_dbg_entry_predictor (
    .cov_assert_if  (cov_assert_if),
    .rst_n_i        (rst_n_i),
    .ret_valid_i    (ret_valid_i),
    .ret_ready_o    (ret_ready_o),
    .ret_instr_i    (ret_instr_i),
    .ret_pc_i       (ret_pc_i),
    .ret_npc_i      (ret_npc_i),
    .ret_err_i      (ret_err_i),
    .debug_req_i    (debug_req_i),
    .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .dcsr_step_i    (dcsr_step_i),
    .trig_en_i      (trig_en_i),
    .tdata2_i       (tdata2_i),
    .rec_valid_o    (rec_valid_o),
    .rec_ready_i    (rec_ready_i),
    .rec_cause_o    (rec_cause_o),
    .rec_dpc_o      (rec_dpc_o),
    .debug_mode_o   (debug_mode_o)
  );

  always #4 cov_assert_if = ~cov_assert_if;

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------

  // 16-bit Galois LFSR, maximal length taps
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // Returns 1 when the beat yields a record
  function automatic logic predict_record(
    input  logic                      is_ebreak,
    input  logic                      is_dret,
    input  logic                      trig_hit,
    input  logic                      halt_req,
    input  logic [dbg_pkg::XLEN-1:0]  pc,
    input  logic [dbg_pkg::XLEN-1:0]  npc,
    output dbg_pkg::dbg_cause_e       cause,
    output logic [dbg_pkg::XLEN-1:0]  dpc
  );
    logic hit;
    hit   = 1'b1;
    cause = dbg_pkg::CAUSE_RESUME;
    if (!model_debug) begin
      if (trig_hit) begin
        cause     = dbg_pkg::CAUSE_TRIGGER;
        model_dpc = pc;
      end else if (is_ebreak && dcsr_ebreakm_i) begin
        cause     = dbg_pkg::CAUSE_EBREAK;
        model_dpc = pc;
      end else if (halt_req) begin
        cause     = dbg_pkg::CAUSE_HALTREQ;
        model_dpc = npc;
      end else if (dcsr_step_i) begin
        cause     = dbg_pkg::CAUSE_STEP;
        model_dpc = npc;
      end else begin
        hit = 1'b0;
      end
      model_debug = hit;
    end else if (is_ebreak) begin
      cause = dbg_pkg::CAUSE_EBREAK;
    end else if (is_dret) begin
      model_debug = 1'b0;
    end else begin
      hit = 1'b0;
    end
    dpc = model_dpc;
    return hit;
  endfunction

  task automatic check_cause(input dbg_pkg::dbg_cause_e exp, input dbg_pkg::dbg_cause_e act);
    if (act !== exp) begin
      $display("[FAIL] %s: cause expected %0d, actual %0d", test_name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_dpc(input logic [dbg_pkg::XLEN-1:0] exp,
                           input logic [dbg_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: dpc expected %08h, actual %08h", test_name, exp, act);
      value_errors++;
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic drive_ready();
    logic [31:0] r;
    if (bp_en) begin
      take_bits(1, r);
      rec_ready_i <= r[0];
    end else begin
      rec_ready_i <= 1'b1;
    end
  endtask

  // Holds the beat until an edge where ready was seen high
  task automatic send_beat(input logic [dbg_pkg::XLEN-1:0] instr,
                           input logic [dbg_pkg::XLEN-1:0] pc,
                           input logic [dbg_pkg::XLEN-1:0] npc,
                           input logic err,
                           input logic req);
    logic accepted;
    ret_valid_i <= 1'b1;
    ret_instr_i <= instr;
    ret_pc_i    <= pc;
    ret_npc_i   <= npc;
    ret_err_i   <= err;
    debug_req_i <= req;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge cov_assert_if);
      accepted = ret_ready_o;
      @(posedge cov_assert_if);
      drive_ready();
    end
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        err;
    take_bits(3, r);
    case (r[2:0])
      3'd0:       instr = dbg_pkg::EBREAK_OPCODE;
      3'd1:       instr = dbg_pkg::CEBREAK_OPCODE;
      3'd2, 3'd3: instr = dbg_pkg::DRET_OPCODE;
      default: begin
        take_bits(16, r);
        instr = {r[15:0], 16'h0013};
      end
    endcase
    // Four pcs from 0x100, one of them the trigger address
    take_bits(2, r);
    pc = {28'h000_0010, r[1:0], 2'b00};
    take_bits(3, r);
    err = (r[2:0] == 3'd0);
    take_bits(3, r);
    send_beat(instr, pc, pc + 32'd4, err, r[2:0] == 3'd0);
  endtask

  // Only called while idle
  task automatic set_config(input logic ebreakm, input logic step, input logic trig_en,
                            input logic [dbg_pkg::XLEN-1:0] tdata2);
    dcsr_ebreakm_i <= ebreakm;
    dcsr_step_i    <= step;
    trig_en_i      <= trig_en;
    tdata2_i       <= tdata2;
    @(posedge cov_assert_if);
  endtask

  task automatic drain_and_check();
    int quiet;
    int waited;
    ret_valid_i <= 1'b0;
    rec_ready_i <= 1'b1;
    quiet  = 0;
    waited = 0;
    while ((exp_cause_q.size() != 0 || quiet < QUIET_CYCLES) && waited < DRAIN_LIMIT) begin
      @(negedge cov_assert_if);
      quiet = rec_valid_o ? 0 : quiet + 1;
      @(posedge cov_assert_if);
      waited++;
    end
    if (exp_cause_q.size() != 0) begin
      $display("%s: %0d expected records never came out of the DUT",
               test_name, exp_cause_q.size());
      other_errors++;
      exp_cause_q.delete();
      exp_dpc_q.delete();
    end
    @(negedge cov_assert_if);
    if (debug_mode_o !== model_debug) begin
      $display("[FAIL] %s: debug_mode_o expected %0b, actual %0b",
               test_name, model_debug, debug_mode_o);
      value_errors++;
    end
    @(posedge cov_assert_if);
  endtask

  // ----------------------------------------
  // Monitors, sampled between clock edges
  // ----------------------------------------

  always @(negedge cov_assert_if) begin : predict_beats
    logic                      is_ebreak;
    logic                      is_dret;
    dbg_pkg::dbg_cause_e       cause;
    logic [dbg_pkg::XLEN-1:0]  dpc;
    if (rst_n_i && ret_valid_i && ret_ready_o) begin
      is_ebreak = !ret_err_i && ((ret_instr_i == dbg_pkg::EBREAK_OPCODE) ||
                                 (ret_instr_i == dbg_pkg::CEBREAK_OPCODE));
      is_dret   = !ret_err_i && (ret_instr_i == dbg_pkg::DRET_OPCODE);
      if (predict_record(is_ebreak, is_dret, trig_en_i && (ret_pc_i == tdata2_i),
                         debug_req_i, ret_pc_i, ret_npc_i, cause, dpc)) begin
        exp_cause_q.push_back(cause);
        exp_dpc_q.push_back(dpc);
      end
    end
  end

  always @(negedge cov_assert_if) begin : compare_records
    dbg_pkg::dbg_cause_e       exp_cause;
    logic [dbg_pkg::XLEN-1:0]  exp_dpc;
    if (rst_n_i && rec_valid_o && rec_ready_i) begin
      if (exp_cause_q.size() == 0) begin
        $display("%s: DUT sent a record with cause %0d that the model did not expect",
                 test_name, rec_cause_o);
        other_errors++;
      end else begin
        exp_cause = exp_cause_q.pop_front();
        exp_dpc   = exp_dpc_q.pop_front();
        check_cause(exp_cause, rec_cause_o);
        check_dpc(exp_dpc, rec_dpc_o);
        records_checked++;
      end
    end
  end

  always @(posedge cov_assert_if) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    rst_n_i        <= 1'b0;
    ret_valid_i    <= 1'b0;
    ret_instr_i    <= '0;
    ret_pc_i       <= '0;
    ret_npc_i      <= '0;
    ret_err_i      <= 1'b0;
    debug_req_i    <= 1'b0;
    dcsr_ebreakm_i <= 1'b0;
    dcsr_step_i    <= 1'b0;
    trig_en_i      <= 1'b0;
    tdata2_i       <= '0;
    rec_ready_i    <= 1'b1;
    repeat (16) @(posedge cov_assert_if);
    rst_n_i <= 1'b1;
    @(posedge cov_assert_if);

    // Trigger wins over ebreak and halt request on the same beat
    test_name = "test_trigger";
    set_config(1'b1, 1'b0, 1'b1, 32'h200);
    send_beat(dbg_pkg::EBREAK_OPCODE, 32'h200, 32'h204, 1'b0, 1'b1);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h300, 32'h200, 1'b0, 1'b0);
    send_beat(32'h0000_0013, 32'h204, 32'h208, 1'b0, 1'b1);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h304, 32'h208, 1'b0, 1'b0);
    drain_and_check();

    test_name = "test_ebreak";
    set_config(1'b0, 1'b0, 1'b0, 32'h0);
    send_beat(dbg_pkg::EBREAK_OPCODE, 32'h400, 32'h404, 1'b0, 1'b0);
    send_beat(dbg_pkg::CEBREAK_OPCODE, 32'h404, 32'h406, 1'b0, 1'b0);
    drain_and_check();
    set_config(1'b1, 1'b0, 1'b0, 32'h0);
    send_beat(dbg_pkg::EBREAK_OPCODE, 32'h410, 32'h414, 1'b0, 1'b0);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h500, 32'h410, 1'b0, 1'b0);
    send_beat(dbg_pkg::CEBREAK_OPCODE, 32'h420, 32'h422, 1'b0, 1'b0);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h504, 32'h420, 1'b0, 1'b0);
    // Errored ebreak counts as an ordinary instruction
    send_beat(dbg_pkg::EBREAK_OPCODE, 32'h430, 32'h434, 1'b1, 1'b0);
    drain_and_check();

    test_name = "test_haltreq_step";
    set_config(1'b0, 1'b0, 1'b1, 32'h500);
    send_beat(32'h0000_0013, 32'h504, 32'h508, 1'b0, 1'b1);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h600, 32'h508, 1'b0, 1'b0);
    drain_and_check();
    set_config(1'b0, 1'b1, 1'b0, 32'h0);
    send_beat(32'h0000_0013, 32'h600, 32'h604, 1'b0, 1'b0);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h700, 32'h604, 1'b0, 1'b0);
    send_beat(32'h0000_0013, 32'h604, 32'h608, 1'b0, 1'b0);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h704, 32'h608, 1'b0, 1'b0);
    drain_and_check();

    test_name = "test_debug_mode";
    set_config(1'b0, 1'b0, 1'b0, 32'h0);
    send_beat(32'h0000_0013, 32'h700, 32'h704, 1'b0, 1'b1);
    drain_and_check();
    send_beat(dbg_pkg::EBREAK_OPCODE, 32'h800, 32'h804, 1'b0, 1'b0);
    send_beat(dbg_pkg::CEBREAK_OPCODE, 32'h804, 32'h806, 1'b0, 1'b0);
    send_beat(32'h0000_0013, 32'h806, 32'h80A, 1'b0, 1'b1);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h80A, 32'h704, 1'b0, 1'b0);
    send_beat(dbg_pkg::DRET_OPCODE, 32'h704, 32'h708, 1'b0, 1'b0);
    drain_and_check();

    test_name = "test_backpressure";
    set_config(1'b1, 1'b0, 1'b1, 32'h108);
    bp_en = 1'b1;
    repeat (N_RANDOM) send_random();
    bp_en = 1'b0;
    drain_and_check();

    $display("Checked %0d records: %0d value errors, %0d other errors",
             records_checked, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/dbg_entry_predictor_chk.sv
// ----------------------------------------
// Handshake checker for the predictor top
// Stability of both streams, legal causes
// ----------------------------------------

`timescale 1ns/1ps

module dbg_entry_predictor_chk (
  input logic                      cov_assert_if,
  input logic                      rst_n_i,
  input logic                      ret_valid_i,
  input logic                      ret_ready_i,
  input logic [dbg_pkg::XLEN-1:0]  ret_instr_i,
  input logic [dbg_pkg::XLEN-1:0]  ret_pc_i,
  input logic [dbg_pkg::XLEN-1:0]  ret_npc_i,
  input logic                      ret_err_i,
  input logic                      debug_req_i,
  input logic                      rec_valid_i,
  input logic                      rec_ready_i,
  input dbg_pkg::dbg_cause_e       rec_cause_i,
  input logic [dbg_pkg::XLEN-1:0]  rec_dpc_i
);

  // Stalled record keeps its fields until taken
  rec_stable_a : assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    rec_valid_i && !rec_ready_i |=> rec_valid_i && $stable(rec_cause_i) && $stable(rec_dpc_i)
  ) else $error("record output changed while held by back-pressure");

  rec_cause_a : assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    rec_valid_i |-> (rec_cause_i inside {dbg_pkg::CAUSE_RESUME, dbg_pkg::CAUSE_EBREAK,
                                         dbg_pkg::CAUSE_TRIGGER, dbg_pkg::CAUSE_HALTREQ,
                                         dbg_pkg::CAUSE_STEP})
  ) else $error("record cause is not a known code");

  // Beat waiting for ready must not move
  ret_stable_a : assert property (@(posedge cov_assert_if) disable iff (!rst_n_i)
    ret_valid_i && !ret_ready_i |=> ret_valid_i && $stable(ret_instr_i) &&
      $stable(ret_pc_i) && $stable(ret_npc_i) && $stable(ret_err_i) && $stable(debug_req_i)
  ) else $error("retire beat changed before it was accepted");

endmodule

bind dbg_entry_predictor dbg_entry_predictor_chk u_chk (
  .cov_assert_if (cov_assert_if),
  .rst_n_i       (rst_n_i),
  .ret_valid_i   (ret_valid_i),
  .ret_ready_i   (ret_ready_o),
  .ret_instr_i   (ret_instr_i),
  .ret_pc_i      (ret_pc_i),
  .ret_npc_i     (ret_npc_i),
  .ret_err_i     (ret_err_i),
  .debug_req_i   (debug_req_i),
  .rec_valid_i   (rec_valid_o),
  .rec_ready_i   (rec_ready_i),
  .rec_cause_i   (rec_cause_o),
  .rec_dpc_i     (rec_dpc_o)
);

//--- rtl/dbg_entry_predictor.sv
// ----------------------------------------
// Debug entry predictor top level
// Decoder, event FIFO, cause tracker and
// record FIFO in one valid/ready chain
// ----------------------------------------

`timescale 1ns/1ps

module dbg_entry_predictor (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  // Retire stream
  input  logic                      ret_valid_i,
  output logic                      ret_ready_o,
  input  logic [dbg_pkg::XLEN-1:0]  ret_instr_i,
  input  logic [dbg_pkg::XLEN-1:0]  ret_pc_i,
  input  logic [dbg_pkg::XLEN-1:0]  ret_npc_i,
  input  logic                      ret_err_i,
  input  logic                      debug_req_i,
  // Quasi-static configuration
  input  logic                      dcsr_ebreakm_i,
  input  logic                      dcsr_step_i,
  input  logic                      trig_en_i,
  input  logic [dbg_pkg::XLEN-1:0]  tdata2_i,
  // Record stream
  output logic                      rec_valid_o,
  input  logic                      rec_ready_i,
  output dbg_pkg::dbg_cause_e       rec_cause_o,
  output logic [dbg_pkg::XLEN-1:0]  rec_dpc_o,
  output logic                      debug_mode_o
);

  // Decoder to event FIFO
  logic                   dec_valid;
  logic                   dec_ready;
  dbg_pkg::dbg_event_t    dec_ev;
  // Event FIFO to tracker
  logic                   trk_ev_valid;
  logic                   trk_ev_ready;
  dbg_pkg::dbg_event_t    trk_ev;
  // Tracker to record FIFO
  logic                   trk_rec_valid;
  logic                   trk_rec_ready;
  dbg_pkg::dbg_record_t   trk_rec;
  // Record FIFO head
  dbg_pkg::dbg_record_t   out_rec;

  dbg_retire_decoder u_decoder (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .ret_valid_i   (ret_valid_i),
    .ret_ready_o   (ret_ready_o),
    .ret_instr_i   (ret_instr_i),
    .ret_pc_i      (ret_pc_i),
    .ret_npc_i     (ret_npc_i),
    .ret_err_i     (ret_err_i),
    .debug_req_i   (debug_req_i),
    .trig_en_i     (trig_en_i),
    .tdata2_i      (tdata2_i),
    .ev_valid_o    (dec_valid),
    .ev_ready_i    (dec_ready),
    .ev_o          (dec_ev)
  );

  dbg_fifo #(
    .item_t (dbg_pkg::dbg_event_t),
    .DEPTH  (dbg_pkg::EVENT_FIFO_DEPTH)
  ) u_event_fifo (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (dec_valid),
    .in_ready_o    (dec_ready),
    .in_item_i     (dec_ev),
    .out_valid_o   (trk_ev_valid),
    .out_ready_i   (trk_ev_ready),
    .out_item_o    (trk_ev)
  );

  dbg_cause_tracker u_tracker (
    .cov_assert_if  (cov_assert_if),
    .rst_n_i        (rst_n_i),
    .ev_valid_i     (trk_ev_valid),
    .ev_ready_o     (trk_ev_ready),
    .ev_i           (trk_ev),
    .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .dcsr_step_i    (dcsr_step_i),
    .rec_valid_o    (trk_rec_valid),
    .rec_ready_i    (trk_rec_ready),
    .rec_o          (trk_rec),
    .debug_mode_o   (debug_mode_o)
  );

  dbg_fifo #(
    .item_t (dbg_pkg::dbg_record_t),
    .DEPTH  (dbg_pkg::RECORD_FIFO_DEPTH)
  ) u_record_fifo (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (trk_rec_valid),
    .in_ready_o    (trk_rec_ready),
    .in_item_i     (trk_rec),
    .out_valid_o   (rec_valid_o),
    .out_ready_i   (rec_ready_i),
    .out_item_o    (out_rec)
  );

  // Record fields out as loose ports
  assign rec_cause_o = out_rec.cause;
  assign rec_dpc_o   = out_rec.dpc;

endmodule

//--- rtl/dbg_cause_tracker.sv
// ----------------------------------------
// Debug cause tracker
// Follows debug mode, ranks entry causes,
// predicts dpc and emits one record each
// ----------------------------------------

`timescale 1ns/1ps

module dbg_cause_tracker (
  input  logic                   cov_assert_if,
  input  logic                   rst_n_i,
  // Event stream
  input  logic                   ev_valid_i,
  output logic                   ev_ready_o,
  input  dbg_pkg::dbg_event_t    ev_i,
  // Static configuration
  input  logic                   dcsr_ebreakm_i,
  input  logic                   dcsr_step_i,
  // Record stream
  output logic                   rec_valid_o,
  input  logic                   rec_ready_i,
  output dbg_pkg::dbg_record_t   rec_o,
  output logic                   debug_mode_o
);

  logic                          debug_mode_q;
  logic [dbg_pkg::XLEN-1:0]      dpc_q;
  logic                          rec_valid_q;
  dbg_pkg::dbg_record_t          rec_q;

  logic                          consume;
  logic                          emit;
  logic                          enter;
  logic                          leave;
  dbg_pkg::dbg_cause_e           cause_d;
  logic [dbg_pkg::XLEN-1:0]      dpc_d;

  // One event per cycle while the record slot can take a result
  assign ev_ready_o = !rec_valid_q || rec_ready_i;
  assign consume    = ev_valid_i && ev_ready_o;

  // ----------------------------------------
  // Cause selection
  // ----------------------------------------
  always_comb begin
    emit    = 1'b0;
    enter   = 1'b0;
    leave   = 1'b0;
    cause_d = dbg_pkg::CAUSE_RESUME;
    dpc_d   = dpc_q;
    if (!debug_mode_q) begin
      // Priority: trigger, ebreak, halt request, single step
      enter = 1'b1;
      if (ev_i.trig_hit) begin
        cause_d = dbg_pkg::CAUSE_TRIGGER;
        dpc_d   = ev_i.pc;
      end else if (dcsr_ebreakm_i && (ev_i.kind == dbg_pkg::KIND_EBREAK)) begin
        cause_d = dbg_pkg::CAUSE_EBREAK;
        dpc_d   = ev_i.pc;
      end else if (ev_i.halt_req) begin
        cause_d = dbg_pkg::CAUSE_HALTREQ;
        dpc_d   = ev_i.npc;
      end else if (dcsr_step_i) begin
        cause_d = dbg_pkg::CAUSE_STEP;
        dpc_d   = ev_i.npc;
      end else begin
        enter = 1'b0;
      end
      emit = enter;
    end else begin
      // In debug mode dpc is frozen
      if (ev_i.kind == dbg_pkg::KIND_EBREAK) begin
        emit    = 1'b1;
        cause_d = dbg_pkg::CAUSE_EBREAK;
      end else if (ev_i.kind == dbg_pkg::KIND_DRET) begin
        emit    = 1'b1;
        leave   = 1'b1;
        cause_d = dbg_pkg::CAUSE_RESUME;
      end
    end
  end

  // ----------------------------------------
  // Mode and record state
  // ----------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      debug_mode_q <= 1'b0;
      rec_valid_q  <= 1'b0;
    end else begin
      if (consume && enter) begin
        debug_mode_q <= 1'b1;
      end else if (consume && leave) begin
        debug_mode_q <= 1'b0;
      end
      if (consume && emit) begin
        rec_valid_q <= 1'b1;
      end else if (rec_ready_i) begin
        rec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (consume && enter) begin
      dpc_q <= dpc_d;
    end
    if (consume && emit) begin
      rec_q.cause <= cause_d;
      rec_q.dpc   <= dpc_d;
    end
  end

  assign rec_valid_o  = rec_valid_q;
  assign rec_o        = rec_q;
  assign debug_mode_o = debug_mode_q;

endmodule

//--- rtl/dbg_fifo.sv
// ----------------------------------------
// Synchronous FIFO
// Circular buffer with valid/ready on both
// sides, carrying any packed payload type
// ----------------------------------------

`timescale 1ns/1ps

module dbg_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 2
) (
  input  logic   cov_assert_if,
  input  logic   rst_n_i,
  // Write side
  input  logic   in_valid_i,
  output logic   in_ready_o,
  input  item_t  in_item_i,
  // Read side
  output logic   out_valid_o,
  input  logic   out_ready_i,
  output item_t  out_item_o
);

  item_t                           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]        wr_ptr;
  logic [$clog2(DEPTH)-1:0]        rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]      count;
  logic                            full;
  logic                            do_wr;
  logic                            do_rd;

  assign full        = (int'(count) == DEPTH);
  assign out_valid_o = (count != '0);
  // A full FIFO still takes a write while it is being read
  assign in_ready_o  = !full || out_ready_i;

  assign do_wr = in_valid_i && in_ready_o;
  assign do_rd = out_valid_o && out_ready_i;

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge cov_assert_if) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_item_i;
    end
  end

  assign out_item_o = mem[rd_ptr];

endmodule

//--- rtl/dbg_retire_decoder.sv
// ----------------------------------------
// Retire decoder
// Classifies each accepted retire beat and
// holds it as an event in one output slot
// ----------------------------------------

`timescale 1ns/1ps

module dbg_retire_decoder (
  input  logic                      cov_assert_if,
  input  logic                      rst_n_i,
  // Retire stream
  input  logic                      ret_valid_i,
  output logic                      ret_ready_o,
  input  logic [dbg_pkg::XLEN-1:0]  ret_instr_i,
  input  logic [dbg_pkg::XLEN-1:0]  ret_pc_i,
  input  logic [dbg_pkg::XLEN-1:0]  ret_npc_i,
  input  logic                      ret_err_i,
  input  logic                      debug_req_i,
  // Trigger setup
  input  logic                      trig_en_i,
  input  logic [dbg_pkg::XLEN-1:0]  tdata2_i,
  // Event stream
  output logic                      ev_valid_o,
  input  logic                      ev_ready_i,
  output dbg_pkg::dbg_event_t       ev_o
);

  logic                 ev_valid_q;
  dbg_pkg::dbg_event_t  ev_q;
  dbg_pkg::dbg_event_t  ev_d;
  logic                 accept;

  // Slot is free when empty or drained this cycle
  assign ret_ready_o = !ev_valid_q || ev_ready_i;
  assign accept      = ret_valid_i && ret_ready_o;

  // ----------------------------------------
  // Classification
  // ----------------------------------------
  always_comb begin
    ev_d.kind = dbg_pkg::KIND_OTHER;
    if (!ret_err_i) begin
      if ((ret_instr_i == dbg_pkg::EBREAK_OPCODE) ||
          (ret_instr_i == dbg_pkg::CEBREAK_OPCODE)) begin
        ev_d.kind = dbg_pkg::KIND_EBREAK;
      end else if (ret_instr_i == dbg_pkg::DRET_OPCODE) begin
        ev_d.kind = dbg_pkg::KIND_DRET;
      end
    end
    // Address match on the retiring pc
    ev_d.trig_hit = trig_en_i && (ret_pc_i == tdata2_i);
    ev_d.halt_req = debug_req_i;
    ev_d.pc       = ret_pc_i;
    ev_d.npc      = ret_npc_i;
  end

  // ----------------------------------------
  // Output slot
  // ----------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      ev_valid_q <= 1'b0;
    end else if (accept) begin
      ev_valid_q <= 1'b1;
    end else if (ev_ready_i) begin
      ev_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (accept) begin
      ev_q <= ev_d;
    end
  end

  assign ev_valid_o = ev_valid_q;
  assign ev_o       = ev_q;

endmodule

//--- rtl/dbg_pkg.sv
// ----------------------------------------
// Debug entry predictor package
// Opcodes, widths, cause codes and the
// event and record types shared by the RTL
// ----------------------------------------

package dbg_pkg;

  // ----------------------------------------
  // Widths and depths
  // ----------------------------------------

  // Pc and instruction word width
  localparam int XLEN = 32;

  // Queue depths between the pipeline blocks
  localparam int EVENT_FIFO_DEPTH  = 4;
  localparam int RECORD_FIFO_DEPTH = 2;

  // ----------------------------------------
  // Instruction encodings
  // ----------------------------------------

  localparam logic [XLEN-1:0] EBREAK_OPCODE  = 32'h0010_0073;
  // Compressed ebreak sits in the low half of the word
  localparam logic [XLEN-1:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [XLEN-1:0] DRET_OPCODE    = 32'h7B20_0073;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // Instruction class, c.ebreak folds into KIND_EBREAK
  typedef enum logic [1:0] {
    KIND_OTHER  = 2'd0,
    KIND_EBREAK = 2'd1,
    KIND_DRET   = 2'd2
  } dbg_kind_e;

  // Numbering follows dcsr.cause, zero marks a dret exit
  typedef enum logic [2:0] {
    CAUSE_RESUME  = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  // One classified retire beat
  typedef struct packed {
    dbg_kind_e         kind;
    logic              trig_hit;
    logic              halt_req;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   npc;
  } dbg_event_t;

  // Debug mode entry, re-entry or exit
  typedef struct packed {
    dbg_cause_e        cause;
    logic [XLEN-1:0]   dpc;
  } dbg_record_t;

endpackage
